// File: sources.f
+incdir+include
hdl/dbg_cfg_pkg.sv
hdl/dbg_proto_pkg.sv
hdl/hart_dbg_unit.sv
hdl/dbg_req_front.sv
hdl/dbg_req_fifo.sv
hdl/dbg_dport_ic.sv
hdl/dbg_workgroup.sv
testbench/dbg_checker.sv
testbench/tb_dbg_workgroup.sv

// File: Bender.yml
package:
  name: dbg_workgroup

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dbg_cfg_pkg.sv
      - hdl/dbg_proto_pkg.sv
      - hdl/hart_dbg_unit.sv
      - hdl/dbg_req_front.sv
      - hdl/dbg_req_fifo.sv
      - hdl/dbg_dport_ic.sv
      - hdl/dbg_workgroup.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/dbg_checker.sv
      - testbench/tb_dbg_workgroup.sv

// File: testbench/tb_dbg_workgroup.sv
// ====================
// Testbench for the debug-port workgroup, built with cpu_num = 3 so that
// slot 3 is absent. Commands are driven on the falling edge and
// responses are acked after a random delay of 0 to 6 cycles.
// All result checking sits in dbg_checker.
// ====================
`timescale 1ns/1ps

module tb_dbg_workgroup;

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    localparam int unsigned CPU_NUM     = 3;
    localparam logic [31:0] RND_SEED    = 32'h32dc9180;
    localparam int          N_CMDS      = 317;     // All phases together
    localparam int          HOLD_CYCLES = 150;     // Response ack withheld
    localparam int          DRAIN_LIMIT = 40 * 6;  // Front, queue and interconnect hold six
    localparam int          CYCLE_LIMIT = 40 * N_CMDS + 200 + HOLD_CYCLES + DRAIN_LIMIT;

    logic          clk;
    logic          rst;
    logic          cmd_req;
    dbg_cmd_e      cmd_type;
    hart_idx_t     cmd_hart;
    dbg_reg_addr_t cmd_addr;
    dbg_data_t     cmd_wdata;
    logic          cmd_ack;
    logic          resp_req;
    dbg_tag_t      resp_tag;
    dbg_data_t     resp_rdata;
    logic          resp_error;
    logic          resp_ack;
    hart_vec_t     halted;
    logic          hold_ack;
    logic          final_chk;
    int            n_sent;
    int            cycles;
    int            drain_cycles;
    int            err_cnt;
    int            check_cnt;
    int            resp_cnt;

    dbg_workgroup #(
        .cpu_num (CPU_NUM)
    ) dut_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_cmd_req    (cmd_req),
        .i_cmd_type   (cmd_type),
        .i_cmd_hart   (cmd_hart),
        .i_cmd_addr   (cmd_addr),
        .i_cmd_wdata  (cmd_wdata),
        .o_cmd_ack    (cmd_ack),
        .o_resp_req   (resp_req),
        .o_resp_tag   (resp_tag),
        .o_resp_rdata (resp_rdata),
        .o_resp_error (resp_error),
        .i_resp_ack   (resp_ack),
        .o_halted     (halted)
    );

    dbg_checker #(
        .cpu_num (CPU_NUM)
    ) chk_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_cmd_ack    (cmd_ack),
        .i_cmd_type   (cmd_type),
        .i_cmd_hart   (cmd_hart),
        .i_cmd_addr   (cmd_addr),
        .i_cmd_wdata  (cmd_wdata),
        .i_resp_req   (resp_req),
        .i_resp_tag   (resp_tag),
        .i_resp_rdata (resp_rdata),
        .i_resp_error (resp_error),
        .i_halted     (halted),
        .i_final      (final_chk),
        .o_err_cnt    (err_cnt),
        .o_check_cnt  (check_cnt),
        .o_resp_cnt   (resp_cnt)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Four-phase host handshake for one command
    task automatic send_cmd(input dbg_cmd_e t, input hart_idx_t h,
                            input dbg_reg_addr_t a, input dbg_data_t wd);
        @(negedge clk);
        cmd_type  = t;
        cmd_hart  = h;
        cmd_addr  = a;
        cmd_wdata = wd;
        cmd_req   = 1'b1;
        do @(negedge clk); while (!cmd_ack);
        cmd_req = 1'b0;
        do @(negedge clk); while (cmd_ack);
        n_sent++;
    endtask

    task automatic send_random_cmd();
        send_cmd(dbg_cmd_e'($urandom % 4), hart_idx_t'($urandom % 4),
                 dbg_reg_addr_t'($urandom % 8), $urandom);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d of %0d responses",
                 check_cnt, err_cnt, timed_out, resp_cnt, n_sent);
        if (!timed_out && err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin : main
        rst          = 1'b1;
        cmd_req      = 1'b0;
        cmd_type     = CMD_HALT;
        cmd_hart     = '0;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        resp_ack     = 1'b0;
        hold_ack     = 1'b0;
        final_chk    = 1'b0;
        n_sent       = 0;
        cycles       = 0;
        drain_cycles = 0;
        void'($urandom(RND_SEED));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Running harts refuse register access and slot 3 always errs
        for (int h = 0; h < 4; h++) begin
            send_cmd(CMD_READ, hart_idx_t'(h), dbg_reg_addr_t'(h), '0);
            send_cmd(CMD_WRITE, hart_idx_t'(h), dbg_reg_addr_t'(h), $urandom);
        end
        for (int h = 0; h < 4; h++) begin
            send_cmd(CMD_HALT, hart_idx_t'(h), '0, '0);
        end
        // Registers read 0 after reset
        for (int h = 0; h < 3; h++) begin
            for (int a = 0; a < 8; a++) begin
                send_cmd(CMD_READ, hart_idx_t'(h), dbg_reg_addr_t'(a), '0);
            end
        end
        for (int h = 0; h < 4; h++) begin
            for (int a = 0; a < 8; a++) begin
                send_cmd(CMD_WRITE, hart_idx_t'(h), dbg_reg_addr_t'(a), $urandom);
            end
        end
        for (int h = 0; h < 4; h++) begin
            for (int a = 0; a < 8; a++) begin
                send_cmd(CMD_READ, hart_idx_t'(h), dbg_reg_addr_t'(a), '0);
            end
        end
        // Resume locks hart 1 again and a new halt brings back its old value
        send_cmd(CMD_RESUME, 2'd1, '0, '0);
        send_cmd(CMD_READ, 2'd1, 3'd2, '0);
        send_cmd(CMD_WRITE, 2'd1, 3'd2, 32'hdead_beef);
        send_cmd(CMD_HALT, 2'd1, '0, '0);
        send_cmd(CMD_READ, 2'd1, 3'd2, '0);

        repeat (200) send_random_cmd();

        // Long back-pressure fills the queue and stalls the front
        hold_ack = 1'b1;
        fork
            repeat (12) send_random_cmd();
            begin
                repeat (HOLD_CYCLES) @(negedge clk);
                hold_ack = 1'b0;
            end
        join

        // Commands still in flight come back within the drain limit
        while (resp_cnt != n_sent && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cycles++;
        end
        @(negedge clk);
        final_chk = 1'b1;
        repeat (2) @(negedge clk);
        finish_run(1'b0);
    end

    // Response acker with random delay
    initial begin : acker
        int delay;
        forever begin
            @(negedge clk);
            if (resp_req && !resp_ack && !hold_ack) begin
                delay = $urandom % 7;
                repeat (delay) @(negedge clk);
                resp_ack = 1'b1;
                while (resp_req) @(negedge clk);
                resp_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run not finished after %0d cycles, %0d of %0d responses seen",
                     cycles, resp_cnt, n_sent);
            finish_run(1'b1);
        end
    end

endmodule : tb_dbg_workgroup

// File: testbench/dbg_checker.sv
// ====================
// Response checker for the debug-port path.
// Captures each command when the front acks it and predicts its response
// with a model of the halted flags and debug registers.
// Assumes a single reset at the start of the run.
// ====================
`timescale 1ns/1ps

`include "dbg_defs.svh"

module dbg_checker #(
    parameter int unsigned cpu_num = 3
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_cmd_ack,      // Host channel, watched only
    input  dbg_proto_pkg::dbg_cmd_e       i_cmd_type,
    input  dbg_cfg_pkg::hart_idx_t        i_cmd_hart,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_cmd_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_cmd_wdata,
    input  logic                          i_resp_req,
    input  dbg_cfg_pkg::dbg_tag_t         i_resp_tag,
    input  dbg_cfg_pkg::dbg_data_t        i_resp_rdata,
    input  logic                          i_resp_error,
    input  dbg_cfg_pkg::hart_vec_t        i_halted,
    input  logic                          i_final,        // End of stimulus
    output int                            o_err_cnt,
    output int                            o_check_cnt,
    output int                            o_resp_cnt
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    localparam int REG_NUM = 2 ** `DBG_REG_ADDR_W;

    typedef struct packed {
        dbg_cmd_e      cmd;
        hart_idx_t     hart;
        dbg_reg_addr_t addr;
        dbg_data_t     wdata;
    } cmd_rec_t;

    cmd_rec_t  cmd_q [$];                       // Accepted, not yet answered
    logic      m_halted [`DBG_CPU_MAX];
    dbg_data_t m_regs [`DBG_CPU_MAX][REG_NUM];
    dbg_tag_t  m_tag;
    logic      r_ack_d;
    logic      r_resp_d;
    logic      r_final_done;

    // Expected response of one command, updates the model state
    function automatic void ref_exec(input cmd_rec_t c, output dbg_tag_t tag,
                                     output dbg_data_t rdata, output logic err);
        tag   = m_tag;
        m_tag = m_tag + 1'b1;    // Wraps at 16
        rdata = '0;
        err   = 1'b0;
        if (c.hart >= cpu_num) begin
            err = 1'b1;          // Absent slot answers like a dummy CPU
        end else begin
            case (c.cmd)
                CMD_HALT:   m_halted[c.hart] = 1'b1;
                CMD_RESUME: m_halted[c.hart] = 1'b0;
                CMD_READ: begin
                    if (m_halted[c.hart]) begin
                        rdata = m_regs[c.hart][c.addr];
                    end else begin
                        err = 1'b1;
                    end
                end
                default: begin
                    if (m_halted[c.hart]) begin
                        m_regs[c.hart][c.addr] = c.wdata;
                    end else begin
                        err = 1'b1;
                    end
                end
            endcase
        end
    endfunction

    function automatic hart_vec_t model_halted_vec();
        hart_vec_t v;
        for (int h = 0; h < `DBG_CPU_MAX; h++) begin
            v[h] = m_halted[h];
        end
        return v;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        o_check_cnt++;
        if (act !== exp) begin
            o_err_cnt++;
            $display("CHECK FAILED at time %0t: %s expected %h actual %h",
                     $time, name, exp, act);
        end
    endtask

    task automatic reset_model();
        cmd_q.delete();
        m_tag = '0;
        for (int h = 0; h < `DBG_CPU_MAX; h++) begin
            m_halted[h] = 1'b0;
            for (int a = 0; a < REG_NUM; a++) begin
                m_regs[h][a] = '0;
            end
        end
    endtask

    initial begin
        o_err_cnt    = 0;
        o_check_cnt  = 0;
        o_resp_cnt   = 0;
        r_ack_d      = 1'b0;
        r_resp_d     = 1'b0;
        r_final_done = 1'b0;
    end

    // Falling edge sampling, all DUT outputs settle after the rising edge
    always @(negedge i_clk) begin : watch
        cmd_rec_t  c;
        dbg_tag_t  exp_tag;
        dbg_data_t exp_rdata;
        logic      exp_err;

        if (i_rst) begin
            reset_model();
        end else begin
            if (i_cmd_ack && !r_ack_d) begin
                c.cmd   = i_cmd_type;
                c.hart  = i_cmd_hart;
                c.addr  = i_cmd_addr;
                c.wdata = i_cmd_wdata;
                cmd_q.push_back(c);
            end
            if (i_resp_req && !r_resp_d) begin
                o_resp_cnt++;
                if (cmd_q.size() == 0) begin
                    o_err_cnt++;
                    $display("Extra response with tag %h at time %0t, no command was pending",
                             i_resp_tag, $time);
                end else begin
                    c = cmd_q.pop_front();
                    ref_exec(c, exp_tag, exp_rdata, exp_err);
                    compare_field("o_resp_tag", 32'(exp_tag), 32'(i_resp_tag));
                    compare_field("o_resp_rdata", exp_rdata, i_resp_rdata);
                    compare_field("o_resp_error", 32'(exp_err), 32'(i_resp_error));
                    compare_field("o_halted", 32'(model_halted_vec()), 32'(i_halted));
                end
            end
            if (i_final && !r_final_done) begin
                r_final_done = 1'b1;
                if (cmd_q.size() != 0) begin
                    o_err_cnt += cmd_q.size();
                    $display("Missing responses: %0d accepted commands were never answered",
                             cmd_q.size());
                end
            end
        end
        r_ack_d  = i_cmd_ack;
        r_resp_d = i_resp_req;
    end

endmodule : dbg_checker

// File: hdl/dbg_workgroup.sv
// ====================
// Debug-port path of the workgroup: command front, request queue and
// interconnect with the hart units.
// cpu_num is 1 to DBG_CPU_MAX. Commands to higher slots get an error.
// Responses keep command order.
// ====================
`timescale 1ns/1ps

module dbg_workgroup #(
    parameter int unsigned cpu_num = 3
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_cmd_req,
    input  dbg_proto_pkg::dbg_cmd_e       i_cmd_type,
    input  dbg_cfg_pkg::hart_idx_t        i_cmd_hart,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_cmd_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_cmd_wdata,
    output logic                          o_cmd_ack,
    output logic                          o_resp_req,
    output dbg_cfg_pkg::dbg_tag_t         o_resp_tag,
    output dbg_cfg_pkg::dbg_data_t        o_resp_rdata,
    output logic                          o_resp_error,
    input  logic                          i_resp_ack,
    output dbg_cfg_pkg::hart_vec_t        o_halted   // Halted flag per hart slot
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    // Front to queue
    logic          w_qi_req;
    dbg_cmd_e      w_qi_type;
    hart_idx_t     w_qi_hart;
    dbg_reg_addr_t w_qi_addr;
    dbg_data_t     w_qi_wdata;
    dbg_tag_t      w_qi_tag;
    logic          w_qi_ack;

    // Queue to interconnect
    logic          w_qo_req;
    dbg_cmd_e      w_qo_type;
    hart_idx_t     w_qo_hart;
    dbg_reg_addr_t w_qo_addr;
    dbg_data_t     w_qo_wdata;
    dbg_tag_t      w_qo_tag;
    logic          w_qo_ack;

    dbg_req_front front_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cmd_req   (i_cmd_req),
        .i_cmd_type  (i_cmd_type),
        .i_cmd_hart  (i_cmd_hart),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_wdata (i_cmd_wdata),
        .o_cmd_ack   (o_cmd_ack),
        .o_q_req     (w_qi_req),
        .o_q_type    (w_qi_type),
        .o_q_hart    (w_qi_hart),
        .o_q_addr    (w_qi_addr),
        .o_q_wdata   (w_qi_wdata),
        .o_q_tag     (w_qi_tag),
        .i_q_ack     (w_qi_ack)
    );

    dbg_req_fifo fifo_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_in_req    (w_qi_req),
        .i_in_type   (w_qi_type),
        .i_in_hart   (w_qi_hart),
        .i_in_addr   (w_qi_addr),
        .i_in_wdata  (w_qi_wdata),
        .i_in_tag    (w_qi_tag),
        .o_in_ack    (w_qi_ack),
        .o_out_req   (w_qo_req),
        .o_out_type  (w_qo_type),
        .o_out_hart  (w_qo_hart),
        .o_out_addr  (w_qo_addr),
        .o_out_wdata (w_qo_wdata),
        .o_out_tag   (w_qo_tag),
        .i_out_ack   (w_qo_ack)
    );

    dbg_dport_ic #(
        .cpu_num (cpu_num)
    ) dport_ic_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_q_req      (w_qo_req),
        .i_q_type     (w_qo_type),
        .i_q_hart     (w_qo_hart),
        .i_q_addr     (w_qo_addr),
        .i_q_wdata    (w_qo_wdata),
        .i_q_tag      (w_qo_tag),
        .o_q_ack      (w_qo_ack),
        .o_resp_req   (o_resp_req),
        .o_resp_tag   (o_resp_tag),
        .o_resp_rdata (o_resp_rdata),
        .o_resp_error (o_resp_error),
        .i_resp_ack   (i_resp_ack),
        .o_halted     (o_halted)
    );

endmodule : dbg_workgroup

// File: hdl/dbg_dport_ic.sv
// ====================
// Debug-port interconnect. Serves one request at a time: pop, execute on
// the selected hart unit, then answer.
// cpu_num sets the present harts, 1 to DBG_CPU_MAX. Slots at or above it
// answer with an error and report not halted.
// ====================
`timescale 1ns/1ps

`include "dbg_defs.svh"

module dbg_dport_ic #(
    parameter int unsigned cpu_num = 1
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_q_req,      // Queue-out channel
    input  dbg_proto_pkg::dbg_cmd_e       i_q_type,
    input  dbg_cfg_pkg::hart_idx_t        i_q_hart,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_q_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_q_wdata,
    input  dbg_cfg_pkg::dbg_tag_t         i_q_tag,
    output logic                          o_q_ack,
    output logic                          o_resp_req,   // Response channel
    output dbg_cfg_pkg::dbg_tag_t         o_resp_tag,
    output dbg_cfg_pkg::dbg_data_t        o_resp_rdata,
    output logic                          o_resp_error,
    input  logic                          i_resp_ack,
    output dbg_cfg_pkg::hart_vec_t        o_halted
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    dbg_cmd_e      r_type;
    hart_idx_t     r_hart;
    dbg_reg_addr_t r_addr;
    dbg_data_t     r_wdata;
    dbg_tag_t      r_tag;
    logic          r_busy;    // Request in service until the response closes
    logic          r_exec;    // Execute cycle, one after ack rises
    hs_state_e     r_state;
    logic          w_accept;

    logic [cpu_num-1:0] w_access;
    dbg_data_t          w_rdata [`DBG_CPU_MAX];
    hart_vec_t          w_error;
    hart_vec_t          w_halted;

    assign w_accept = i_q_req && !o_q_ack && !r_busy;

    for (genvar i = 0; i < cpu_num; i++) begin : g_hart
        assign w_access[i] = r_exec && (r_hart == hart_idx_t'(i));

        hart_dbg_unit unit_i (
            .i_clk    (i_clk),
            .i_rst    (i_rst),
            .i_access (w_access[i]),
            .i_type   (r_type),
            .i_addr   (r_addr),
            .i_wdata  (r_wdata),
            .o_rdata  (w_rdata[i]),
            .o_error  (w_error[i]),
            .o_halted (w_halted[i])
        );
    end : g_hart

    // Empty slot behaves like a dummy CPU
    for (genvar i = cpu_num; i < `DBG_CPU_MAX; i++) begin : g_absent
        assign w_rdata[i]  = '0;
        assign w_error[i]  = 1'b1;
        assign w_halted[i] = 1'b0;
    end : g_absent

    assign o_halted = w_halted;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_q_ack    <= 1'b0;
            o_resp_req <= 1'b0;
            r_busy     <= 1'b0;
            r_exec     <= 1'b0;
            r_state    <= HS_IDLE;
        end else begin
            r_exec <= w_accept;
            if (w_accept) begin
                o_q_ack <= 1'b1;
                r_busy  <= 1'b1;
            end else if (o_q_ack && !i_q_req) begin
                o_q_ack <= 1'b0;
            end

            case (r_state)
                HS_IDLE: begin
                    if (r_exec) begin
                        o_resp_req <= 1'b1;
                        r_state    <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (i_resp_ack) begin
                        o_resp_req <= 1'b0;
                        r_state    <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    if (!i_resp_ack) begin
                        r_busy  <= 1'b0;   // Next request may be taken
                        r_state <= HS_IDLE;
                    end
                end
                default: r_state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            r_type  <= i_q_type;
            r_hart  <= i_q_hart;
            r_addr  <= i_q_addr;
            r_wdata <= i_q_wdata;
            r_tag   <= i_q_tag;
        end
        if (r_exec) begin
            o_resp_tag   <= r_tag;
            o_resp_rdata <= w_rdata[r_hart];  // Unit outputs show the pre-access state
            o_resp_error <= w_error[r_hart];
        end
    end

endmodule : dbg_dport_ic

// File: hdl/dbg_req_fifo.sv
// ====================
// Request queue with four-phase channels on both sides.
// Holds up to DBG_FIFO_DEPTH requests. When it is full the input ack is
// withheld until an entry leaves.
// ====================
`timescale 1ns/1ps

`include "dbg_defs.svh"

module dbg_req_fifo (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_in_req,
    input  dbg_proto_pkg::dbg_cmd_e       i_in_type,
    input  dbg_cfg_pkg::hart_idx_t        i_in_hart,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_in_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_in_wdata,
    input  dbg_cfg_pkg::dbg_tag_t         i_in_tag,
    output logic                          o_in_ack,
    output logic                          o_out_req,
    output dbg_proto_pkg::dbg_cmd_e       o_out_type,
    output dbg_cfg_pkg::hart_idx_t        o_out_hart,
    output dbg_cfg_pkg::dbg_reg_addr_t    o_out_addr,
    output dbg_cfg_pkg::dbg_data_t        o_out_wdata,
    output dbg_cfg_pkg::dbg_tag_t         o_out_tag,
    input  logic                          i_out_ack
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    localparam int PTR_W = $clog2(`DBG_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`DBG_FIFO_DEPTH + 1);

    dbg_cmd_e      m_type  [`DBG_FIFO_DEPTH];
    hart_idx_t     m_hart  [`DBG_FIFO_DEPTH];
    dbg_reg_addr_t m_addr  [`DBG_FIFO_DEPTH];
    dbg_data_t     m_wdata [`DBG_FIFO_DEPTH];
    dbg_tag_t      m_tag   [`DBG_FIFO_DEPTH];

    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    hs_state_e        r_state;
    logic             w_push;
    logic             w_pop;

    assign w_push = i_in_req && !o_in_ack && (r_count != CNT_W'(`DBG_FIFO_DEPTH));
    assign w_pop  = (r_state == HS_REQ) && i_out_ack;   // Entry leaves on ack rise

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_in_ack  <= 1'b0;
            o_out_req <= 1'b0;
            r_wr_ptr  <= '0;
            r_rd_ptr  <= '0;
            r_count   <= '0;
            r_state   <= HS_IDLE;
        end else begin
            if (w_push) begin
                o_in_ack <= 1'b1;
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end else if (o_in_ack && !i_in_req) begin
                o_in_ack <= 1'b0;
            end

            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            if (w_push && !w_pop) begin
                r_count <= r_count + 1'b1;
            end else if (w_pop && !w_push) begin
                r_count <= r_count - 1'b1;
            end

            case (r_state)
                HS_IDLE: begin
                    if (r_count != '0) begin
                        o_out_req <= 1'b1;
                        r_state   <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (i_out_ack) begin
                        o_out_req <= 1'b0;
                        r_state   <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    if (!i_out_ack) r_state <= HS_IDLE;
                end
                default: r_state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            m_type[r_wr_ptr]  <= i_in_type;
            m_hart[r_wr_ptr]  <= i_in_hart;
            m_addr[r_wr_ptr]  <= i_in_addr;
            m_wdata[r_wr_ptr] <= i_in_wdata;
            m_tag[r_wr_ptr]   <= i_in_tag;
        end
    end

    // Head stays put while o_out_req is high, the read pointer moves only on pop
    assign o_out_type  = m_type[r_rd_ptr];
    assign o_out_hart  = m_hart[r_rd_ptr];
    assign o_out_addr  = m_addr[r_rd_ptr];
    assign o_out_wdata = m_wdata[r_rd_ptr];
    assign o_out_tag   = m_tag[r_rd_ptr];

endmodule : dbg_req_fifo

// File: hdl/dbg_req_front.sv
// ====================
// Host command front. Holds a single command, so one command can wait
// here while others sit in the queue.
// Tags start at 0 after reset and wrap at 2**DBG_TAG_W.
// ====================
`timescale 1ns/1ps

module dbg_req_front (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_cmd_req,    // Host command channel
    input  dbg_proto_pkg::dbg_cmd_e       i_cmd_type,
    input  dbg_cfg_pkg::hart_idx_t        i_cmd_hart,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_cmd_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_cmd_wdata,
    output logic                          o_cmd_ack,
    output logic                          o_q_req,      // Queue-in channel
    output dbg_proto_pkg::dbg_cmd_e       o_q_type,
    output dbg_cfg_pkg::hart_idx_t        o_q_hart,
    output dbg_cfg_pkg::dbg_reg_addr_t    o_q_addr,
    output dbg_cfg_pkg::dbg_data_t        o_q_wdata,
    output dbg_cfg_pkg::dbg_tag_t         o_q_tag,
    input  logic                          i_q_ack
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    logic      r_full;       // Command register occupied
    dbg_tag_t  r_tag_cnt;
    hs_state_e r_state;
    logic      w_accept;

    // New command only after the previous host handshake has closed
    assign w_accept = i_cmd_req && !o_cmd_ack && !r_full;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cmd_ack <= 1'b0;
            o_q_req   <= 1'b0;
            r_full    <= 1'b0;
            r_tag_cnt <= '0;
            r_state   <= HS_IDLE;
        end else begin
            if (w_accept) begin
                o_cmd_ack <= 1'b1;
                r_full    <= 1'b1;
                r_tag_cnt <= r_tag_cnt + 1'b1;
            end else if (o_cmd_ack && !i_cmd_req) begin
                o_cmd_ack <= 1'b0;  // Host released req
            end

            case (r_state)
                HS_IDLE: begin
                    if (r_full) begin
                        o_q_req <= 1'b1;
                        r_state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (i_q_ack) begin
                        o_q_req <= 1'b0;
                        r_state <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    // Slot frees only once the queue has dropped ack
                    if (!i_q_ack) begin
                        r_full  <= 1'b0;
                        r_state <= HS_IDLE;
                    end
                end
                default: r_state <= HS_IDLE;
            endcase
        end
    end

    // Command register is loaded only while empty, so it is stable under o_q_req
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_q_type  <= i_cmd_type;
            o_q_hart  <= i_cmd_hart;
            o_q_addr  <= i_cmd_addr;
            o_q_wdata <= i_cmd_wdata;
            o_q_tag   <= r_tag_cnt;
        end
    end

endmodule : dbg_req_front

// File: hdl/hart_dbg_unit.sv
// ====================
// Debug state of one hart: halted flag and eight debug registers.
// Register access is refused with an error while the hart runs.
// Halt and resume always succeed.
// ====================
`timescale 1ns/1ps

`include "dbg_defs.svh"

module hart_dbg_unit (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_access,   // One-cycle command strobe
    input  dbg_proto_pkg::dbg_cmd_e       i_type,
    input  dbg_cfg_pkg::dbg_reg_addr_t    i_addr,
    input  dbg_cfg_pkg::dbg_data_t        i_wdata,
    output dbg_cfg_pkg::dbg_data_t        o_rdata,
    output logic                          o_error,
    output logic                          o_halted
);

    import dbg_cfg_pkg::*;
    import dbg_proto_pkg::*;

    localparam int REG_NUM = 2 ** `DBG_REG_ADDR_W;

    logic      r_halted;
    dbg_data_t r_regs [REG_NUM];
    logic      w_reg_cmd;

    assign w_reg_cmd = (i_type == CMD_READ) || (i_type == CMD_WRITE);

    assign o_error  = w_reg_cmd && !r_halted;
    assign o_rdata  = (r_halted && i_type == CMD_READ) ? r_regs[i_addr] : '0;
    assign o_halted = r_halted;

    // Register file clears on reset, reads after reset must return 0
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_halted <= 1'b0;
            for (int i = 0; i < REG_NUM; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_access) begin
            case (i_type)
                CMD_HALT:   r_halted <= 1'b1;
                CMD_RESUME: r_halted <= 1'b0;
                CMD_WRITE: begin
                    if (r_halted) r_regs[i_addr] <= i_wdata;  // Dropped while running
                end
                default: ;  // Read has no side effect
            endcase
        end
    end

endmodule : hart_dbg_unit

// File: hdl/dbg_proto_pkg.sv
// ====================
// Debug command codes and handshake states.
// The command encoding is fixed at two bits, so the four codes are all
// there is.
// ====================
package dbg_proto_pkg;

    // Debug command issued by the host
    typedef enum logic [1:0] {
        CMD_HALT   = 2'd0,
        CMD_RESUME = 2'd1,
        CMD_READ   = 2'd2,
        CMD_WRITE  = 2'd3
    } dbg_cmd_e;

    // Sender side of a four-phase req/ack channel
    typedef enum logic [1:0] {
        HS_IDLE    = 2'd0,  // Nothing offered
        HS_REQ     = 2'd1,  // req high, waiting for ack
        HS_RELEASE = 2'd2   // req dropped, waiting for ack to fall
    } hs_state_e;

endpackage : dbg_proto_pkg

// File: hdl/dbg_cfg_pkg.sv
// ====================
// Width types for the debug-port path.
// All sizes come from dbg_defs.svh and none are set here.
// ====================
`include "dbg_defs.svh"

package dbg_cfg_pkg;

    typedef logic [$clog2(`DBG_CPU_MAX)-1:0] hart_idx_t;   // Hart slot number
    typedef logic [`DBG_DATA_W-1:0]          dbg_data_t;   // Debug register value
    typedef logic [`DBG_REG_ADDR_W-1:0]      dbg_reg_addr_t;
    typedef logic [`DBG_TAG_W-1:0]           dbg_tag_t;    // Command order tag

    // One bit per hart slot, absent slots included
    typedef logic [`DBG_CPU_MAX-1:0] hart_vec_t;

endpackage : dbg_cfg_pkg

// File: include/dbg_defs.svh
// ====================
// Sizing of the debug-port path.
// DBG_CPU_MAX must be a power of two so that a hart index covers every slot.
// DBG_FIFO_DEPTH must be a power of two, because the FIFO pointers wrap
// on their own width.
// ====================
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Hart slots in the workgroup
`define DBG_CPU_MAX 4

// Debug register width
`define DBG_DATA_W 32

// Eight debug registers per hart
`define DBG_REG_ADDR_W 3

// Sequence tag, wraps at 16
`define DBG_TAG_W 4

// Request queue entries
`define DBG_FIFO_DEPTH 4

`endif
